/* src/fetch_pkg.sv */
package fetch_pkg;

	// ################################################
	// Datapath widths
	// ################################################
	localparam int ADDR_WIDTH = 32;
	localparam int INST_WIDTH = 32;

	// First fetch after reset
	localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;

	// ################################################
	// RV32I major opcodes seen by the predictor
	// ################################################
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

endpackage : fetch_pkg

/* src/branch_predict.sv */
module branch_predict (
	input  logic                            enq_valid,
	input  logic [fetch_pkg::INST_WIDTH-1:0] enq_inst,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] enq_pc,
	output logic                            bp_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] bp_target
);

	import fetch_pkg::*;

	logic [6:0]            opcode;
	logic                  is_jal;
	logic                  is_branch;
	logic                  backward;
	logic [ADDR_WIDTH-1:0] j_imm;
	logic [ADDR_WIDTH-1:0] b_imm;

	assign opcode    = enq_inst[6:0];
	assign is_jal    = opcode == OPC_JAL;
	assign is_branch = opcode == OPC_BRANCH;

	// ################################################
	// Immediate assembly
	// ################################################
	// J-type: imm[20|10:1|11|19:12]
	assign j_imm = {
		{(ADDR_WIDTH - 20){enq_inst[31]}},
		enq_inst[19:12],
		enq_inst[20],
		enq_inst[30:21],
		1'b0
	};

	// B-type: imm[12|10:5] ... imm[4:1|11]
	assign b_imm = {
		{(ADDR_WIDTH - 12){enq_inst[31]}},
		enq_inst[7],
		enq_inst[30:25],
		enq_inst[11:8],
		1'b0
	};

	// Sign bit set means a loop back edge
	assign backward = enq_inst[31];

	// ################################################
	// Prediction
	// ################################################
	assign bp_valid  = enq_valid && (is_jal || (is_branch && backward));
	assign bp_target = enq_pc + (is_jal ? j_imm : b_imm);

endmodule : branch_predict

/* src/fetch_unit.sv */
module fetch_unit (
	input  logic                            clk_in,
	input  logic                            rst_in,
	input  logic                            rdy_in,

	// Cache side
	input  logic                            cache_miss,
	input  logic [fetch_pkg::INST_WIDTH-1:0] cache_inst,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_addr,

	// Queue side
	output logic                            enq_valid,
	output logic [fetch_pkg::INST_WIDTH-1:0] enq_inst,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] enq_pc,
	input  logic                            queue_ready,

	// Redirect sources
	input  logic                            bp_valid,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] bp_target,
	input  logic                            decoder_valid,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] decoder_target,
	input  logic                            rob_valid,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] rob_target
);

	import fetch_pkg::*;

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		PENDING = 2'b01,
		LOCKED  = 2'b10
	} state_t;

	state_t state;
	logic [ADDR_WIDTH-1:0] pc;
	logic [ADDR_WIDTH-1:0] pc_temp;

	logic                  redir_valid;
	logic [ADDR_WIDTH-1:0] redir_target;
	logic [ADDR_WIDTH-1:0] seq_next;

	// ################################################
	// Redirect arbitration, ROB first
	// ################################################
	assign redir_valid = (state != LOCKED) && (rob_valid || decoder_valid || bp_valid);

	assign redir_target = rob_valid     ? rob_target :
	                      decoder_valid ? decoder_target :
	                                      bp_target;

	// Held address wins once the stalled word goes in
	assign seq_next = (state == IDLE) ? pc + ADDR_WIDTH'(4) : pc_temp;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			pc         <= RESET_PC;
			fetch_addr <= RESET_PC;
			enq_valid  <= 1'b0;
			state      <= IDLE;
		end else if (!rdy_in) begin
			// Stalled, enqueue pulse still ends
			enq_valid <= 1'b0;
		end else if (redir_valid) begin
			enq_valid <= 1'b0;
			if (rob_valid || state == IDLE) begin
				pc         <= redir_target;
				fetch_addr <= redir_target;
				state      <= IDLE;
			end else begin
				// Word at pc still owed to the queue
				pc_temp <= redir_target;
				state   <= LOCKED;
			end
		end else if (!cache_miss && queue_ready) begin
			enq_valid  <= 1'b1;
			enq_inst   <= cache_inst;
			enq_pc     <= pc;
			pc         <= seq_next;
			fetch_addr <= seq_next;
			state      <= IDLE;
		end else begin
			enq_valid <= 1'b0;
			if (!cache_miss && state == IDLE) begin
				pc_temp <= pc + ADDR_WIDTH'(4);
				state   <= PENDING;
			end
		end
	end

endmodule : fetch_unit

/* src/icache.sv */
module icache #(
	parameter int CACHE_INDEX_BITS = 4
) (
	input  logic                            clk_in,
	input  logic                            rst_in,

	// Lookup
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_addr,
	output logic                            cache_miss,
	output logic [fetch_pkg::INST_WIDTH-1:0] cache_inst,

	// External memory
	output logic                            mem_req,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] mem_addr,
	input  logic [fetch_pkg::INST_WIDTH-1:0] mem_data,
	input  logic                            mem_valid
);

	import fetch_pkg::*;

	localparam int LINES = 1 << CACHE_INDEX_BITS;
	localparam int TAG_W = ADDR_WIDTH - CACHE_INDEX_BITS - 2;

	logic [TAG_W-1:0]      tag_mem  [LINES];
	logic [INST_WIDTH-1:0] data_mem [LINES];
	logic [LINES-1:0]      valid_bits;

	logic [CACHE_INDEX_BITS-1:0] rd_index;
	logic [TAG_W-1:0]            rd_tag;
	logic [CACHE_INDEX_BITS-1:0] fill_index;
	logic [TAG_W-1:0]            fill_tag;
	logic                        fill_done;

	// ################################################
	// Hit path
	// ################################################
	assign rd_index = fetch_addr[CACHE_INDEX_BITS+1:2];
	assign rd_tag   = fetch_addr[ADDR_WIDTH-1:CACHE_INDEX_BITS+2];

	assign cache_miss = !(valid_bits[rd_index] && (tag_mem[rd_index] == rd_tag));
	assign cache_inst = data_mem[rd_index];

	// ################################################
	// Miss handling
	// ################################################
	// Fill slot comes from the latched request, not fetch_addr
	assign fill_index = mem_addr[CACHE_INDEX_BITS+1:2];
	assign fill_tag   = mem_addr[ADDR_WIDTH-1:CACHE_INDEX_BITS+2];
	assign fill_done  = mem_req && mem_valid;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			mem_req    <= 1'b0;
			valid_bits <= '0;
		end else if (mem_req) begin
			if (mem_valid) begin
				mem_req                <= 1'b0;
				valid_bits[fill_index] <= 1'b1;
			end
		end else if (cache_miss) begin
			mem_req  <= 1'b1;
			mem_addr <= {fetch_addr[ADDR_WIDTH-1:2], 2'b00};
		end
	end

	// Line contents
	always_ff @(posedge clk_in) begin
		if (fill_done) begin
			tag_mem[fill_index]  <= fill_tag;
			data_mem[fill_index] <= mem_data;
		end
	end

endmodule : icache

/* src/inst_queue.sv */
module inst_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                            clk_in,
	input  logic                            rst_in,
	input  logic                            flush,

	input  logic                            enq_valid,
	input  logic [fetch_pkg::INST_WIDTH-1:0] enq_inst,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] enq_pc,
	output logic                            queue_ready,

	input  logic                            deq_ready,
	output logic                            deq_valid,
	output logic [fetch_pkg::INST_WIDTH-1:0] deq_inst,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] deq_pc
);

	import fetch_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam int LAST  = QUEUE_DEPTH - 1;

	localparam logic [PTR_W-1:0] LAST_PTR  = LAST[PTR_W-1:0];
	localparam logic [CNT_W-1:0] DEPTH_CNT = QUEUE_DEPTH[CNT_W-1:0];

	logic [INST_WIDTH-1:0] inst_mem [QUEUE_DEPTH];
	logic [ADDR_WIDTH-1:0] pc_mem   [QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W:0]   fill_next;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == LAST_PTR)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign push = enq_valid && (count < DEPTH_CNT);
	assign pop  = deq_ready && (count != '0);

	// Lookahead, the enqueue register adds a cycle of latency
	assign fill_next   = {1'b0, count} + {{CNT_W{1'b0}}, enq_valid};
	assign queue_ready = fill_next < {1'b0, DEPTH_CNT};

	assign deq_valid = count != '0;
	assign deq_inst  = inst_mem[rd_ptr];
	assign deq_pc    = pc_mem[rd_ptr];

	// ################################################
	// Pointers and count
	// ################################################
	always_ff @(posedge clk_in) begin
		if (rst_in || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_in) begin
		if (push && !flush) begin
			inst_mem[wr_ptr] <= enq_inst;
			pc_mem[wr_ptr]   <= enq_pc;
		end
	end

endmodule : inst_queue

/* src/fetch_top.sv */
module fetch_top #(
	parameter int CACHE_INDEX_BITS = 4,
	parameter int QUEUE_DEPTH      = 4
) (
	input  logic                            clk_in,
	input  logic                            rst_in,
	input  logic                            rdy_in,

	// External memory
	output logic                            mem_req,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] mem_addr,
	input  logic [fetch_pkg::INST_WIDTH-1:0] mem_data,
	input  logic                            mem_valid,

	// Redirects from later stages
	input  logic                            decoder_valid,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] decoder_target,
	input  logic                            rob_valid,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] rob_target,

	// Consumer
	input  logic                            deq_ready,
	output logic                            deq_valid,
	output logic [fetch_pkg::INST_WIDTH-1:0] deq_inst,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] deq_pc
);

	import fetch_pkg::*;

	logic                  cache_miss;
	logic [INST_WIDTH-1:0] cache_inst;
	logic [ADDR_WIDTH-1:0] fetch_addr;
	logic                  enq_valid;
	logic [INST_WIDTH-1:0] enq_inst;
	logic [ADDR_WIDTH-1:0] enq_pc;
	logic                  queue_ready;
	logic                  bp_valid;
	logic [ADDR_WIDTH-1:0] bp_target;

	fetch_unit i_fetch_unit (
		.clk_in         (clk_in),
		.rst_in         (rst_in),
		.rdy_in         (rdy_in),
		.cache_miss     (cache_miss),
		.cache_inst     (cache_inst),
		.fetch_addr     (fetch_addr),
		.enq_valid      (enq_valid),
		.enq_inst       (enq_inst),
		.enq_pc         (enq_pc),
		.queue_ready    (queue_ready),
		.bp_valid       (bp_valid),
		.bp_target      (bp_target),
		.decoder_valid  (decoder_valid),
		.decoder_target (decoder_target),
		.rob_valid      (rob_valid),
		.rob_target     (rob_target)
	);

	icache #(
		.CACHE_INDEX_BITS (CACHE_INDEX_BITS)
	) i_icache (
		.clk_in     (clk_in),
		.rst_in     (rst_in),
		.fetch_addr (fetch_addr),
		.cache_miss (cache_miss),
		.cache_inst (cache_inst),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_valid  (mem_valid)
	);

	// ROB redirect also drops everything queued
	inst_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) i_inst_queue (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.flush       (rob_valid),
		.enq_valid   (enq_valid),
		.enq_inst    (enq_inst),
		.enq_pc      (enq_pc),
		.queue_ready (queue_ready),
		.deq_ready   (deq_ready),
		.deq_valid   (deq_valid),
		.deq_inst    (deq_inst),
		.deq_pc      (deq_pc)
	);

	branch_predict i_branch_predict (
		.enq_valid (enq_valid),
		.enq_inst  (enq_inst),
		.enq_pc    (enq_pc),
		.bp_valid  (bp_valid),
		.bp_target (bp_target)
	);

endmodule : fetch_top

/* test/fetch_top_props.sv */
module fetch_top_props #(
	parameter int DEPTH = 4
) (
	input logic clk_in,
	input logic rst_in,
	input logic enq_valid,
	input logic rob_valid,
	input logic deq_ready,
	input logic deq_valid,
	input logic mem_req,
	input logic mem_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	int occ;

	// Occupancy seen from the queue ports
	always_ff @(posedge clk_in) begin
		if (rst_in || rob_valid)
			occ <= 0;
		else
			occ <= occ + int'(enq_valid) - int'(deq_ready && deq_valid);
	end

	// ################################################
	// Fetch and queue timing
	// ################################################
	enq_not_full: assert property (@(posedge clk_in) disable iff (rst_in)
		enq_valid |-> occ < DEPTH)
		else $error("enqueue while the queue is full");

	req_held: assert property (@(posedge clk_in) disable iff (rst_in)
		mem_req && !mem_valid |=> mem_req)
		else $error("mem_req dropped before mem_valid");

	flush_empties: assert property (@(posedge clk_in) disable iff (rst_in)
		rob_valid |=> !deq_valid)
		else $error("queue not empty after flush");

	no_enq_after_rob: assert property (@(posedge clk_in) disable iff (rst_in)
		rob_valid |=> !enq_valid)
		else $error("enqueue right after ROB redirect");

endmodule : fetch_top_props

/* test/fetch_top_tb.sv */
module fetch_top_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import fetch_pkg::*;

	localparam int INDEX_BITS = 4;
	localparam int LINES      = 1 << INDEX_BITS;
	localparam int WAIT_LIMIT = 200;
	localparam int SKIP_LIMIT = 8;

	logic clk_in = 1'b0;
	logic rst_in, rdy_in, mem_req, mem_valid;
	logic decoder_valid, rob_valid, deq_ready, deq_valid;
	logic [ADDR_WIDTH-1:0] mem_addr, decoder_target, rob_target, deq_pc;
	logic [INST_WIDTH-1:0] mem_data, deq_inst;

	logic [INST_WIDTH-1:0] image [logic [ADDR_WIDTH-1:0]];
	logic [ADDR_WIDTH-1:0] line_addr [LINES];
	logic [LINES-1:0]      line_ok;
	bit    busy = 1'b0;
	int    delay_left = 0;
	int    seed = 99038;
	int    errors = 0;
	int    timeouts = 0;
	string test_name = "none";

	fetch_top #(
		.CACHE_INDEX_BITS (INDEX_BITS),
		.QUEUE_DEPTH      (4)
	) i_fetch_top (
		.clk_in         (clk_in),
		.rst_in         (rst_in),
		.rdy_in         (rdy_in),
		.mem_req        (mem_req),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.mem_valid      (mem_valid),
		.decoder_valid  (decoder_valid),
		.decoder_target (decoder_target),
		.rob_valid      (rob_valid),
		.rob_target     (rob_target),
		.deq_ready      (deq_ready),
		.deq_valid      (deq_valid),
		.deq_inst       (deq_inst),
		.deq_pc         (deq_pc)
	);

	bind fetch_top fetch_top_props #(.DEPTH(QUEUE_DEPTH)) i_props (
		.clk_in    (clk_in),
		.rst_in    (rst_in),
		.enq_valid (enq_valid),
		.rob_valid (rob_valid),
		.deq_ready (deq_ready),
		.deq_valid (deq_valid),
		.mem_req   (mem_req),
		.mem_valid (mem_valid)
	);

	always #50 clk_in = ~clk_in;

	// Words outside the image are non-branch ALU ops
	function automatic logic [INST_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
		if (image.exists(addr))
			return image[addr];
		return {addr[24:0] ^ addr[31:7], 7'h13};
	endfunction

	// ##################################################
	// Memory model
	// ##################################################
	always @(posedge clk_in) begin
		#5;
		if (mem_valid) begin
			mem_valid = 1'b0;
		end else if (mem_req) begin
			if (!busy) begin
				if (line_ok[mem_addr[INDEX_BITS+1:2]] &&
				    line_addr[mem_addr[INDEX_BITS+1:2]] == mem_addr) begin
					errors++;
					$display("Memory request for %h while that line still holds it", mem_addr);
				end
				busy       = 1'b1;
				delay_left = 1 + ({$random(seed)} % 4);
			end
			delay_left--;
			if (delay_left == 0) begin
				busy      = 1'b0;
				mem_data  = word_at(mem_addr);
				mem_valid = 1'b1;
				line_addr[mem_addr[INDEX_BITS+1:2]] = mem_addr;
				line_ok[mem_addr[INDEX_BITS+1:2]]   = 1'b1;
			end
		end
	end

	task automatic wait_head(output bit ok);
		int n;
		n = 0;
		while (!deq_valid && n < WAIT_LIMIT) begin
			@(posedge clk_in);
			#5;
			n++;
		end
		ok = deq_valid;
		if (!ok) begin
			timeouts++;
			$display("Timeout in %s: queue stayed empty for %0d cycles", test_name, n);
		end
	endtask

	task automatic pop_head();
		deq_ready = 1'b1;
		@(posedge clk_in);
		#5;
		deq_ready = 1'b0;
	endtask

	// A stalled fetch unit lets only an enqueue already in flight land
	task automatic pause_consumer(input int cycles);
		int n;
		bit was_empty;
		was_empty = 1'b0;
		for (n = 0; n < cycles; n++) begin
			@(posedge clk_in);
			#5;
			if (rdy_in) begin
				was_empty = 1'b0;
			end else if (n == 0) begin
				was_empty = !deq_valid;
			end else if (was_empty && deq_valid) begin
				errors++;
				was_empty = 1'b0;
				$display("Queue grew in %s while rdy_in was held low", test_name);
			end
		end
	endtask

	task automatic expect_pc(input logic [ADDR_WIDTH-1:0] pc);
		bit ok;
		wait_head(ok);
		if (ok) begin
			if (deq_pc !== pc) begin
				errors++;
				$display("ERR %s pc expected %h actual %h", test_name, pc, deq_pc);
			end
			if (deq_inst !== word_at(pc)) begin
				errors++;
				$display("ERR %s inst expected %h actual %h", test_name, word_at(pc), deq_inst);
			end
			pop_head();
		end
	endtask

	task automatic redirect(input bit rob, input logic [ADDR_WIDTH-1:0] target);
		rob_valid      = rob;
		rob_target     = target;
		decoder_valid  = !rob;
		decoder_target = target;
		@(posedge clk_in);
		#5;
		rob_valid     = 1'b0;
		decoder_valid = 1'b0;
		if (rob && deq_valid) begin
			errors++;
			$display("ERR %s deq_valid expected 0 actual 1", test_name);
		end
	endtask

	// Older entries may still sit ahead of the target
	task automatic skip_to(input logic [ADDR_WIDTH-1:0] target);
		bit ok;
		int n;
		for (n = 0; n < SKIP_LIMIT; n++) begin
			wait_head(ok);
			if (!ok || deq_pc === target)
				return;
			pop_head();
		end
		errors++;
		$display("Target %h did not appear within %0d entries", target, SKIP_LIMIT);
	endtask

	initial begin
		int fd;
		int cnt;
		string line;
		string cmd;
		logic [31:0] a;
		logic [31:0] b;
		rst_in         = 1'b1;
		rdy_in         = 1'b1;
		mem_valid      = 1'b0;
		mem_data       = '0;
		decoder_valid  = 1'b0;
		decoder_target = '0;
		rob_valid      = 1'b0;
		rob_target     = '0;
		deq_ready      = 1'b0;
		line_ok        = '0;
		repeat (8) @(posedge clk_in);
		#5;
		rst_in = 1'b0;

		fd = $fopen("test/fetch_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open test/fetch_golden.txt");
		end else begin
			while (!$feof(fd) && timeouts == 0) begin
				line = "";
				cnt  = $fgets(line, fd);
				if (cnt <= 0 || line.len() < 2 || line[0] == "#")
					continue;
				cnt = $sscanf(line, "%s %h %h", cmd, a, b);
				case (cmd)
					"M": image[a] = b;
					"T": cnt = $sscanf(line, "%s %s", cmd, test_name);
					"E": expect_pc(a);
					"R": redirect(1'b1, a);
					"D": begin
						redirect(1'b0, a);
						skip_to(a);
					end
					"P": pause_consumer(a);
					"H": rdy_in = a[0];
					default: begin
						errors++;
						$display("Unknown golden line: %s", line);
					end
				endcase
			end
			$fclose(fd);
		end

		$display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule : fetch_top_tb

/* fetch_top.f */
src/fetch_pkg.sv
src/branch_predict.sv
src/fetch_unit.sv
src/icache.sv
src/inst_queue.sv
src/fetch_top.sv
test/fetch_top_props.sv
test/fetch_top_tb.sv

/* Makefile */
TOP := fetch_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module fetch_top -f fetch_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_top.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/fetch_golden.txt */
# M addr word = memory image, other words use the fill pattern
# T name | E pc | R target | D target | P cycles | H rdy_in
M 0000000c ff5ff06f
M 00000024 fe209ee3
T cold_stream
E 00000000
E 00000004
E 00000008
E 0000000c
T cached_loop
E 00000000
E 00000004
P 12
E 00000008
E 0000000c
E 00000000
T rob_redirect
R 00000020
E 00000020
E 00000024
E 00000020
T decoder_redirect
R 00000040
E 00000040
P 10
D 00000080
E 00000080
E 00000084
H 0
P 6
H 1
E 00000088
E 0000008c
